// ==== logic/cgraHost_defines.svh ====
`ifndef CGRA_HOST_DEFINES_SVH
`define CGRA_HOST_DEFINES_SVH

// one host, shared-memory and instruction word
`define DATA_WIDTH 32

// APB address width, used on both the host and shared-memory side
`define ADDR_WIDTH 32

// instruction memory write address, also bounds the word count
`define IM_ADDR_WIDTH 8

// host register map
`define REG_STATUS 0
`define REG_RESET 4
`define REG_CYCLES 8
`define REG_STALLS 12

`endif

// ==== logic/cgraHostPkg.sv ====
`include "cgraHost_defines.svh"

package cgraHostPkg;

	typedef logic [`DATA_WIDTH-1:0] word_t;

	// configuration loader sequence
	typedef enum logic [1:0]
	{
		idle,
		fetchCount,
		fetchWord,
		writeWord
	} loaderState_e;

	// host register select, regNone for unmapped offsets
	typedef enum logic [2:0]
	{
		regStatus,
		regReset,
		regCycles,
		regStalls,
		regNone
	} regSel_e;

endpackage

// ==== logic/memReadIf.sv ====
`include "cgraHost_defines.svh"

interface memReadIf import cgraHostPkg::*; ();

	logic req;
	logic [`ADDR_WIDTH-1:0] addr;
	logic valid;
	word_t data;

	// req and addr are held until valid, data only counts while valid is high
	modport loader
	(
		output req,
		output addr,
		input valid,
		input data
	);

	modport master
	(
		input req,
		input addr,
		output valid,
		output data
	);

endinterface

// ==== logic/hostRegs.sv ====
`include "cgraHost_defines.svh"

module hostRegs import cgraHostPkg::*;
(
	input logic iClk,
	input logic rstN,
	input logic [`ADDR_WIDTH-1:0] hostPaddr,
	input logic hostPsel,
	input logic hostPenable,
	input logic hostPwrite,
	input word_t hostPwdata,
	output word_t hostPrdata,
	output logic hostPready,
	input logic halted,
	input logic stall,
	input logic cgraReset,
	input logic configDone,
	input word_t cycles,
	input word_t stalls,
	output logic start,
	output word_t startAddr,
	output logic hostReset
);

	regSel_e regSel;
	logic writeEn;

	always_comb
	begin
		case (hostPaddr)
			`REG_STATUS: regSel = regStatus;
			`REG_RESET: regSel = regReset;
			`REG_CYCLES: regSel = regCycles;
			`REG_STALLS: regSel = regStalls;
			default: regSel = regNone;
		endcase
	end

	// writes land at the access-phase edge
	assign writeEn = hostPsel && hostPenable && hostPwrite;

	// no wait states
	assign hostPready = 1'b1;

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			start <= 1'b0;
			hostReset <= 1'b1;
		end
		else
		begin
			start <= writeEn && (regSel == regStatus);
			if (writeEn && (regSel == regReset))
				hostReset <= hostPwdata[0];
		end
	end

	// base address for the loader, sampled with the start write
	always_ff @(posedge iClk)
	begin
		if (writeEn && (regSel == regStatus))
			startAddr <= hostPwdata;
	end

	always_comb
	begin
		case (regSel)
			regStatus: hostPrdata = {{(`DATA_WIDTH-4){1'b0}}, stall, cgraReset, halted, configDone};
			regCycles: hostPrdata = cycles;
			regStalls: hostPrdata = stalls;
			default: hostPrdata = '0;
		endcase
	end

	// APB needs a setup phase between two access phases
	startSinglePulse: assert property (@(posedge iClk) disable iff (!rstN) start |=> !start);

endmodule

// ==== logic/configLoader.sv ====
`include "cgraHost_defines.svh"

module configLoader import cgraHostPkg::*;
(
	input logic iClk,
	input logic rstN,
	input logic start,
	input word_t startAddr,
	memReadIf.loader mem,
	output logic imWe,
	output logic [`IM_ADDR_WIDTH-1:0] imAddr,
	output word_t imData,
	output logic loaderReset,
	output logic configDone
);

	loaderState_e state;
	logic [`IM_ADDR_WIDTH-1:0] count;
	logic [`IM_ADDR_WIDTH-1:0] wordIdx;
	logic [`ADDR_WIDTH-1:0] addrR;
	logic reqR;

	assign mem.req = reqR;
	assign mem.addr = addrR;
	assign imAddr = wordIdx;

	// the array stays in reset from the accepted start until the load ends
	assign loaderReset = start || (state != idle);

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= idle;
			count <= '0;
			wordIdx <= '0;
			addrR <= '0;
			reqR <= 1'b0;
			imWe <= 1'b0;
			configDone <= 1'b0;
		end
		else
		begin
			imWe <= 1'b0;
			case (state)
				idle:
				begin
					if (start)
					begin
						addrR <= startAddr;
						wordIdx <= '0;
						reqR <= 1'b1;
						configDone <= 1'b0;
						state <= fetchCount;
					end
				end
				fetchCount:
				begin
					if (mem.valid)
					begin
						// header word, low bits hold the count
						count <= mem.data[`IM_ADDR_WIDTH-1:0];
						reqR <= 1'b0;
						if (mem.data[`IM_ADDR_WIDTH-1:0] == '0)
						begin
							configDone <= 1'b1;
							state <= idle;
						end
						else
						begin
							addrR <= addrR + 'd4;
							state <= fetchWord;
						end
					end
				end
				fetchWord:
				begin
					if (mem.valid)
					begin
						imWe <= 1'b1;
						reqR <= 1'b0;
						state <= writeWord;
					end
					else
						reqR <= 1'b1;
				end
				writeWord:
				begin
					wordIdx <= wordIdx + 1'b1;
					if (wordIdx == count - 1'b1)
					begin
						configDone <= 1'b1;
						state <= idle;
					end
					else
					begin
						addrR <= addrR + 'd4;
						reqR <= 1'b1;
						state <= fetchWord;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge iClk)
	begin
		if ((state == fetchWord) && mem.valid)
			imData <= mem.data;
	end

	// writes come only from writeWord and stay inside the loaded range
	writeOnlyInWriteState: assert property (@(posedge iClk) disable iff (!rstN)
		imWe |-> (state == writeWord) && (wordIdx < count));

endmodule

// ==== logic/smemReadMaster.sv ====
`include "cgraHost_defines.svh"

module smemReadMaster import cgraHostPkg::*;
(
	input logic iClk,
	input logic rstN,
	memReadIf.master mem,
	output logic smemPsel,
	output logic smemPenable,
	output logic [`ADDR_WIDTH-1:0] smemPaddr,
	input word_t smemPrdata,
	input logic smemPready
);

	typedef enum logic [1:0]
	{
		mIdle,
		mSetup,
		mAccess
	} masterState_e;

	masterState_e state;

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= mIdle;
			smemPsel <= 1'b0;
			smemPenable <= 1'b0;
			mem.valid <= 1'b0;
		end
		else
		begin
			mem.valid <= 1'b0;
			case (state)
				mIdle:
				begin
					// req is still high in the valid cycle, so skip that one
					if (mem.req && !mem.valid)
					begin
						smemPsel <= 1'b1;
						state <= mSetup;
					end
				end
				mSetup:
				begin
					smemPenable <= 1'b1;
					state <= mAccess;
				end
				mAccess:
				begin
					if (smemPready)
					begin
						smemPsel <= 1'b0;
						smemPenable <= 1'b0;
						mem.valid <= 1'b1;
						state <= mIdle;
					end
				end
				default: state <= mIdle;
			endcase
		end
	end

	always_ff @(posedge iClk)
	begin
		if ((state == mIdle) && mem.req)
			smemPaddr <= mem.addr;
		if ((state == mAccess) && smemPready)
			mem.data <= smemPrdata;
	end

	// the loader keeps its address for the whole transfer
	accessMatchesRequest: assert property (@(posedge iClk) disable iff (!rstN)
		smemPenable |-> smemPsel && (smemPaddr == mem.addr));

endmodule

// ==== logic/perfCounters.sv ====
`include "cgraHost_defines.svh"

module perfCounters import cgraHostPkg::*;
(
	input logic iClk,
	input logic rstN,
	input logic cgraReset,
	input logic halted,
	input logic stall,
	output word_t cycles,
	output word_t stalls
);

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			cycles <= '0;
			stalls <= '0;
		end
		else if (cgraReset)
		begin
			cycles <= '0;
			stalls <= '0;
		end
		else if (!halted)
		begin
			// only running cycles count, stalls are a subset of them
			cycles <= cycles + 1'b1;
			if (stall)
				stalls <= stalls + 1'b1;
		end
	end

endmodule

// ==== logic/cgraHost.sv ====
`include "cgraHost_defines.svh"

module cgraHost import cgraHostPkg::*;
(
	input logic iClk,
	input logic rstN,
	input logic [`ADDR_WIDTH-1:0] hostPaddr,
	input logic hostPsel,
	input logic hostPenable,
	input logic hostPwrite,
	input word_t hostPwdata,
	output word_t hostPrdata,
	output logic hostPready,
	output logic smemPsel,
	output logic smemPenable,
	output logic [`ADDR_WIDTH-1:0] smemPaddr,
	input word_t smemPrdata,
	input logic smemPready,
	output logic imWe,
	output logic [`IM_ADDR_WIDTH-1:0] imAddr,
	output word_t imData,
	input logic halted,
	input logic stall,
	output logic cgraReset,
	output logic configDone
);

	logic hostReset;
	logic loaderReset;
	logic start;
	word_t startAddr;
	word_t cycles;
	word_t stalls;

	memReadIf memRead ();

	assign cgraReset = hostReset | loaderReset;

	hostRegs i_hostRegs
	(
		.iClk(iClk),
		.rstN(rstN),
		.hostPaddr(hostPaddr),
		.hostPsel(hostPsel),
		.hostPenable(hostPenable),
		.hostPwrite(hostPwrite),
		.hostPwdata(hostPwdata),
		.hostPrdata(hostPrdata),
		.hostPready(hostPready),
		.halted(halted),
		.stall(stall),
		.cgraReset(cgraReset),
		.configDone(configDone),
		.cycles(cycles),
		.stalls(stalls),
		.start(start),
		.startAddr(startAddr),
		.hostReset(hostReset)
	);

	configLoader i_configLoader
	(
		.iClk(iClk),
		.rstN(rstN),
		.start(start),
		.startAddr(startAddr),
		.mem(memRead.loader),
		.imWe(imWe),
		.imAddr(imAddr),
		.imData(imData),
		.loaderReset(loaderReset),
		.configDone(configDone)
	);

	smemReadMaster i_smemReadMaster
	(
		.iClk(iClk),
		.rstN(rstN),
		.mem(memRead.master),
		.smemPsel(smemPsel),
		.smemPenable(smemPenable),
		.smemPaddr(smemPaddr),
		.smemPrdata(smemPrdata),
		.smemPready(smemPready)
	);

	perfCounters i_perfCounters
	(
		.iClk(iClk),
		.rstN(rstN),
		.cgraReset(cgraReset),
		.halted(halted),
		.stall(stall),
		.cycles(cycles),
		.stalls(stalls)
	);

endmodule

// ==== testbench/cgraHostTb.sv ====
`include "cgraHost_defines.svh"

module cgraHostTb import cgraHostPkg::*; ();

	logic iClk = 1'b0;
	logic rstN;
	logic [`ADDR_WIDTH-1:0] hostPaddr;
	logic hostPsel;
	logic hostPenable;
	logic hostPwrite;
	word_t hostPwdata;
	word_t hostPrdata;
	logic hostPready;
	logic smemPsel;
	logic smemPenable;
	logic [`ADDR_WIDTH-1:0] smemPaddr;
	word_t smemPrdata = '0;
	logic smemPready = 1'b0;
	logic imWe;
	logic [`IM_ADDR_WIDTH-1:0] imAddr;
	word_t imData;
	logic halted = 1'b0;
	logic stall = 1'b0;
	logic cgraReset;
	logic configDone;

	// shared memory contents, keyed by byte address
	word_t smemModel [logic [`ADDR_WIDTH-1:0]];
	logic [`IM_ADDR_WIDTH-1:0] imAddrLog [$];
	word_t imDataLog [$];

	int waitTable [1024];
	int flagTable [1024];
	int loadCount [5];
	logic [9:0] waitIdx = '0;
	logic [9:0] flagIdx = '0;
	int waitLeft = 0;

	// 0 quiet, 1 random flags, 2 and 3 halted so the counters hold, 3 also stalls
	logic [1:0] flagMode = 2'd0;
	logic expHostReset = 1'b1;
	word_t expCycles = '0;
	word_t expStalls = '0;

	cgraHost i_cgraHost
	(
		.iClk(iClk),
		.rstN(rstN),
		.hostPaddr(hostPaddr),
		.hostPsel(hostPsel),
		.hostPenable(hostPenable),
		.hostPwrite(hostPwrite),
		.hostPwdata(hostPwdata),
		.hostPrdata(hostPrdata),
		.hostPready(hostPready),
		.smemPsel(smemPsel),
		.smemPenable(smemPenable),
		.smemPaddr(smemPaddr),
		.smemPrdata(smemPrdata),
		.smemPready(smemPready),
		.imWe(imWe),
		.imAddr(imAddr),
		.imData(imData),
		.halted(halted),
		.stall(stall),
		.cgraReset(cgraReset),
		.configDone(configDone)
	);

	always #2 iClk = ~iClk;

	function automatic word_t readSmem(input logic [`ADDR_WIDTH-1:0] addr);
		if (smemModel.exists(addr))
			return smemModel[addr];
		return ~addr;
	endfunction

	function automatic word_t statusWord(input logic stallBit, input logic resetBit,
		input logic haltedBit, input logic doneBit);
		return {{(`DATA_WIDTH-4){1'b0}}, stallBit, resetBit, haltedBit, doneBit};
	endfunction

	task automatic stopRun();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input word_t expected, input word_t actual);
		if (expected !== actual)
		begin
			$display("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
			stopRun();
		end
	endtask

	task automatic runWatchdog(input int limit);
		repeat (limit) @(posedge iClk);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		stopRun();
	endtask

	task automatic hostWrite(input logic [`ADDR_WIDTH-1:0] addr, input word_t data);
		@(posedge iClk);
		hostPsel <= 1'b1;
		hostPenable <= 1'b0;
		hostPwrite <= 1'b1;
		hostPaddr <= addr;
		hostPwdata <= data;
		@(posedge iClk);
		hostPenable <= 1'b1;
		// the write lands at this edge
		@(posedge iClk);
		hostPsel <= 1'b0;
		hostPenable <= 1'b0;
		if (addr == `REG_RESET)
			expHostReset <= data[0];
	endtask

	task automatic hostRead(input logic [`ADDR_WIDTH-1:0] addr, output word_t data);
		@(posedge iClk);
		hostPsel <= 1'b1;
		hostPenable <= 1'b0;
		hostPwrite <= 1'b0;
		hostPaddr <= addr;
		@(posedge iClk);
		hostPenable <= 1'b1;
		@(negedge iClk);
		data = hostPrdata;
		checkValue("hostReady", 32'd1, 32'(hostPready));
		@(posedge iClk);
		hostPsel <= 1'b0;
		hostPenable <= 1'b0;
	endtask

	task automatic runLoad(input int count);
		word_t base;
		word_t header;
		word_t value;
		word_t expWords [$];
		int i;
		base = $urandom() & 32'hffff_fffc;
		header = $urandom();
		header[`IM_ADDR_WIDTH-1:0] = `IM_ADDR_WIDTH'(count);
		smemModel[base] = header;
		for (i = 0; i < count; i++)
		begin
			expWords.push_back($urandom());
			smemModel[base + 32'(4 * (i + 1))] = expWords[i];
		end
		imAddrLog.delete();
		imDataLog.delete();
		hostWrite(`REG_STATUS, base);
		do
			@(negedge iClk);
		while (configDone !== 1'b0);
		// the loader holds the array in reset until configDone rises
		while (configDone !== 1'b1)
		begin
			checkValue("loadResetPin", 32'd1, 32'(cgraReset));
			@(negedge iClk);
		end
		checkValue("loadWriteCount", 32'(count), 32'(imAddrLog.size()));
		for (i = 0; i < count; i++)
		begin
			checkValue("loadImAddr", 32'(i), 32'(imAddrLog[i]));
			checkValue("loadImData", expWords[i], imDataLog[i]);
		end
		hostRead(`REG_STATUS, value);
		checkValue("loadStatus", statusWord(1'b0, expHostReset, 1'b0, 1'b1), value);
	endtask

	// APB slave with 0 to 3 wait states per read
	always @(posedge iClk)
	begin
		if (smemPsel && !smemPenable)
		begin
			waitLeft = waitTable[waitIdx];
			waitIdx = waitIdx + 10'd1;
			smemPready <= (waitLeft == 0);
			smemPrdata <= readSmem(smemPaddr);
		end
		else if (smemPsel && smemPenable)
		begin
			if (smemPready)
				smemPready <= 1'b0;
			else
			begin
				waitLeft = waitLeft - 1;
				if (waitLeft == 0)
					smemPready <= 1'b1;
			end
		end
	end

	always @(posedge iClk)
	begin
		if (imWe === 1'b1)
		begin
			imAddrLog.push_back(imAddr);
			imDataLog.push_back(imData);
		end
	end

	always @(posedge iClk)
	begin
		case (flagMode)
			2'd1:
			begin
				halted <= flagTable[flagIdx][0];
				stall <= flagTable[flagIdx][1];
				flagIdx <= flagIdx + 10'd1;
			end
			2'd2, 2'd3:
			begin
				halted <= 1'b1;
				stall <= flagMode[0];
			end
			default:
			begin
				halted <= 1'b0;
				stall <= 1'b0;
			end
		endcase
	end

	// counter model, sees the flags as they stood before the edge
	always @(posedge iClk)
	begin
		if (expHostReset)
		begin
			expCycles <= '0;
			expStalls <= '0;
		end
		else if (!halted)
		begin
			expCycles <= expCycles + 32'd1;
			if (stall)
				expStalls <= expStalls + 32'd1;
		end
	end

	initial
	begin
		word_t value;
		int totalWords;
		int i;
		void'($urandom(32'heb37));
		rstN = 1'b0;
		hostPaddr = '0;
		hostPsel = 1'b0;
		hostPenable = 1'b0;
		hostPwrite = 1'b0;
		hostPwdata = '0;
		totalWords = 0;
		for (i = 0; i < 1024; i++)
		begin
			waitTable[i] = $urandom_range(0, 3);
			flagTable[i] = $urandom_range(0, 3);
		end
		for (i = 0; i < 5; i++)
		begin
			loadCount[i] = $urandom_range(1, 20);
			totalWords += loadCount[i];
		end
		fork
			runWatchdog(64 * totalWords + 2000);
		join_none
		repeat (16) @(posedge iClk);
		rstN <= 1'b1;
		@(negedge iClk);

		hostRead(`REG_STATUS, value);
		checkValue("resetStatus", statusWord(1'b0, 1'b1, 1'b0, 1'b0), value);
		hostRead(`REG_CYCLES, value);
		checkValue("resetCycles", 32'd0, value);
		hostRead(`REG_STALLS, value);
		checkValue("resetStalls", 32'd0, value);
		hostRead(32'd16, value);
		checkValue("unmappedRead", 32'd0, value);

		for (i = 0; i < 4; i++)
			runLoad(loadCount[i]);
		// header with a count of zero
		runLoad(0);

		hostWrite(`REG_RESET, 32'd0);
		@(negedge iClk);
		checkValue("resetPinLow", 32'd0, 32'(cgraReset));
		hostRead(`REG_STATUS, value);
		checkValue("resetStatusLow", statusWord(1'b0, 1'b0, 1'b0, 1'b1), value);
		// with the host bit low only the loader drives the array reset
		runLoad(loadCount[4]);
		hostWrite(`REG_RESET, 32'd1);
		@(negedge iClk);
		checkValue("resetPinHigh", 32'd1, 32'(cgraReset));
		hostRead(`REG_STATUS, value);
		checkValue("resetStatusHigh", statusWord(1'b0, 1'b1, 1'b0, 1'b1), value);

		hostWrite(`REG_RESET, 32'd0);
		for (i = 0; i < 2; i++)
		begin
			flagMode <= 2'd1;
			repeat (150) @(posedge iClk);
			flagMode <= (i == 0) ? 2'd2 : 2'd3;
			repeat (3) @(posedge iClk);
			hostRead(`REG_CYCLES, value);
			checkValue("cycleCount", expCycles, value);
			hostRead(`REG_STALLS, value);
			checkValue("stallCount", expStalls, value);
			hostRead(`REG_STATUS, value);
			checkValue("heldStatus", statusWord(i[0], 1'b0, 1'b1, 1'b1), value);
		end
		hostWrite(`REG_RESET, 32'd1);
		hostRead(`REG_CYCLES, value);
		checkValue("clearedCycles", 32'd0, value);
		hostRead(`REG_STALLS, value);
		checkValue("clearedStalls", 32'd0, value);

		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== cgraHost.f ====
+incdir+logic
logic/cgraHostPkg.sv
logic/memReadIf.sv
logic/hostRegs.sv
logic/configLoader.sv
logic/smemReadMaster.sv
logic/perfCounters.sv
logic/cgraHost.sv
testbench/cgraHostTb.sv

// ==== Makefile ====
TOP = cgraHostTb
BUILD = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --assert --top-module $(TOP) -f cgraHost.f --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP)

clean:
	rm -rf $(BUILD)
